// ==== common/float_csr_pkg.sv ====
package float_csr_pkg;

  // ============================
  // Field widths
  // ============================
  localparam int ADDR_W   = 12;
  localparam int DATA_W   = 64;
  localparam int FFLAGS_W = 5;
  localparam int FRM_W    = 3;
  localparam int VL_W     = 8;
  localparam int VSTART_W = 7;

  // CSR access port
  typedef logic [ADDR_W-1:0]   csr_addr_t;
  typedef logic [DATA_W-1:0]   csr_data_t;
  // Accrued flags NV DZ OF UF NX, NV in the top bit
  typedef logic [FFLAGS_W-1:0] fflags_t;
  // Dynamic rounding mode
  typedef logic [FRM_W-1:0]    frm_t;
  // Vector length and start index
  typedef logic [VL_W-1:0]     vl_t;
  typedef logic [VSTART_W-1:0] vstart_t;

  // ============================
  // CSR addresses
  // ============================
  localparam csr_addr_t ADDR_FFLAGS = 12'h001;
  localparam csr_addr_t ADDR_FRM    = 12'h002;
  localparam csr_addr_t ADDR_FCSR   = 12'h003;
  localparam csr_addr_t ADDR_VSTART = 12'h008;
  localparam csr_addr_t ADDR_VXSAT  = 12'h009;
  localparam csr_addr_t ADDR_VXRM   = 12'h00A;
  // Custom extension register
  localparam csr_addr_t ADDR_FXCR   = 12'h800;
  // Read-only vector CSRs
  localparam csr_addr_t ADDR_VL     = 12'hC20;
  localparam csr_addr_t ADDR_VTYPE  = 12'hC21;
  localparam csr_addr_t ADDR_VLENB  = 12'hC22;

  // ============================
  // Read select codes
  // ============================
  typedef logic [3:0] csr_sel_t;

  localparam csr_sel_t SEL_NONE   = 4'd0;
  localparam csr_sel_t SEL_FFLAGS = 4'd1;
  localparam csr_sel_t SEL_FRM    = 4'd2;
  localparam csr_sel_t SEL_FCSR   = 4'd3;
  localparam csr_sel_t SEL_VSTART = 4'd4;
  localparam csr_sel_t SEL_VXSAT  = 4'd5;
  localparam csr_sel_t SEL_VXRM   = 4'd6;
  localparam csr_sel_t SEL_VL     = 4'd7;
  localparam csr_sel_t SEL_VTYPE  = 4'd8;
  localparam csr_sel_t SEL_VLENB  = 4'd9;
  localparam csr_sel_t SEL_FXCR   = 4'd10;
  // Unknown address, still answered with zero data
  localparam csr_sel_t SEL_ZERO   = 4'd11;

endpackage

// ==== src/gated_clk_cell.sv ====
`timescale 1ns/1ps

module gated_clk_cell (
  input  logic clk_in,
  input  logic local_en,
  output logic clk_out
);

  // Enable as seen by the AND gate
  logic en_lat;

  // ============================
  // Enable latch
  // ============================
  // Transparent in the low phase of the clock
  // Holds the enable stable through the high phase
  always_latch begin
    if (!clk_in) begin
      en_lat = local_en;
    end
  end

  // ============================
  // Gated clock
  // ============================
  // Latched enable only changes while clk_in is low
  // so the AND output cannot glitch
  assign clk_out = clk_in & en_lat;

endmodule

// ==== float_csr/float_csr_decode.sv ====
`timescale 1ns/1ps

module float_csr_decode (
  input  logic                      float_clk,
  input  logic                      cpurst_b,
  input  logic                      csr_ren,
  input  logic                      csr_wen,
  input  float_csr_pkg::csr_addr_t  csr_addr,
  output logic                      fflags_wen,
  output logic                      frm_wen,
  output logic                      fcsr_wen,
  output logic                      fxcr_wen,
  output float_csr_pkg::csr_sel_t   rd_sel,
  output logic                      csr_illegal
);

  // Address lookup results
  float_csr_pkg::csr_sel_t addr_sel;
  logic                    addr_known;
  logic                    addr_ro;
  // Illegal condition of the current access
  logic                    illegal_nxt;

  // ============================
  // Address lookup
  // ============================
  always_comb begin
    addr_sel   = float_csr_pkg::SEL_ZERO;
    addr_known = 1'b1;
    addr_ro    = 1'b0;
    case (csr_addr)
      float_csr_pkg::ADDR_FFLAGS: begin
        addr_sel = float_csr_pkg::SEL_FFLAGS;
      end
      float_csr_pkg::ADDR_FRM: begin
        addr_sel = float_csr_pkg::SEL_FRM;
      end
      float_csr_pkg::ADDR_FCSR: begin
        addr_sel = float_csr_pkg::SEL_FCSR;
      end
      // WARL zero, writes dropped without a fault
      float_csr_pkg::ADDR_VSTART: begin
        addr_sel = float_csr_pkg::SEL_VSTART;
      end
      float_csr_pkg::ADDR_VXSAT: begin
        addr_sel = float_csr_pkg::SEL_VXSAT;
      end
      float_csr_pkg::ADDR_VXRM: begin
        addr_sel = float_csr_pkg::SEL_VXRM;
      end
      float_csr_pkg::ADDR_FXCR: begin
        addr_sel = float_csr_pkg::SEL_FXCR;
      end
      // Read-only space, a write faults
      float_csr_pkg::ADDR_VL: begin
        addr_sel = float_csr_pkg::SEL_VL;
        addr_ro  = 1'b1;
      end
      float_csr_pkg::ADDR_VTYPE: begin
        addr_sel = float_csr_pkg::SEL_VTYPE;
        addr_ro  = 1'b1;
      end
      float_csr_pkg::ADDR_VLENB: begin
        addr_sel = float_csr_pkg::SEL_VLENB;
        addr_ro  = 1'b1;
      end
      default: begin
        addr_known = 1'b0;
      end
    endcase
  end

  // ============================
  // Write pulses
  // ============================
  assign fflags_wen = csr_wen & (addr_sel == float_csr_pkg::SEL_FFLAGS);
  assign frm_wen    = csr_wen & (addr_sel == float_csr_pkg::SEL_FRM);
  assign fcsr_wen   = csr_wen & (addr_sel == float_csr_pkg::SEL_FCSR);
  assign fxcr_wen   = csr_wen & (addr_sel == float_csr_pkg::SEL_FXCR);

  // Read select, idle code when no read
  assign rd_sel = csr_ren ? addr_sel : float_csr_pkg::SEL_NONE;

  // ============================
  // Illegal access pulse
  // ============================
  // Unknown address on any access, or write to read-only space
  assign illegal_nxt = ((csr_ren | csr_wen) & ~addr_known) | (csr_wen & addr_ro);

  always_ff @(posedge float_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      csr_illegal <= 1'b0;
    end
    else begin
      csr_illegal <= illegal_nxt;
    end
  end

endmodule

// ==== float_csr/float_csr_regs.sv ====
`timescale 1ns/1ps

module float_csr_regs #(
  parameter int VLEN = 128
) (
  input  logic                      float_clk,
  input  logic                      cpurst_b,
  input  logic                      fflags_wen,
  input  logic                      frm_wen,
  input  logic                      fcsr_wen,
  input  logic                      fxcr_wen,
  input  float_csr_pkg::csr_sel_t   rd_sel,
  input  float_csr_pkg::csr_data_t  csr_wdata,
  input  logic                      retire_fflags_vld,
  input  float_csr_pkg::fflags_t    retire_fflags,
  input  logic                      vsetvl_bypass,
  input  logic                      vsetvl_illegal,
  input  logic                      vsetvl_vill,
  input  logic [4:0]                vsetvl_data,
  input  float_csr_pkg::csr_data_t  vsetvl_avl,
  output float_csr_pkg::csr_data_t  csr_rdata,
  output logic                      csr_rdata_vld,
  output float_csr_pkg::frm_t       frm,
  output logic                      dqnan,
  output logic                      bf16,
  output logic                      idu_vill,
  output logic                      idu_vl_zero,
  output logic [1:0]                idu_vlmul,
  output logic [1:0]                idu_vsew,
  output float_csr_pkg::vstart_t    idu_vstart,
  output logic                      vstart_eq_0
);

  // Architectural state
  float_csr_pkg::fflags_t   fcsr_fflags;
  float_csr_pkg::frm_t      fcsr_frm;
  logic                     fxcr_fe;
  logic                     fxcr_dqnan;
  logic                     fxcr_bf16;
  // Hardwired vector state
  float_csr_pkg::vstart_t   vstart_vstart;
  logic                     fcsr_vxsat;
  logic [1:0]               fcsr_vxrm;
  float_csr_pkg::vl_t       vl_vl;
  logic                     vtype_vill;
  logic [2:0]               vtype_vsew;
  logic [1:0]               vtype_vlmul;
  // Flag clock
  logic                     flag_clk_en;
  logic                     flag_clk;
  // Any write that loads fflags from wdata
  logic                     fflags_load;
  logic                     vl_bypass_zero;
  // Read views
  float_csr_pkg::csr_data_t fflags_value;
  float_csr_pkg::csr_data_t frm_value;
  float_csr_pkg::csr_data_t fcsr_value;
  float_csr_pkg::csr_data_t fxcr_value;
  float_csr_pkg::csr_data_t vstart_value;
  float_csr_pkg::csr_data_t vxsat_value;
  float_csr_pkg::csr_data_t vxrm_value;
  float_csr_pkg::csr_data_t vl_value;
  float_csr_pkg::csr_data_t vtype_value;
  float_csr_pkg::csr_data_t vlenb_value;
  float_csr_pkg::csr_data_t rd_value;

  // ============================
  // Flag clock gate
  // ============================
  // Runs only on a CSR write or a retire update
  assign flag_clk_en = fflags_wen | frm_wen | fcsr_wen | fxcr_wen | retire_fflags_vld;

  gated_clk_cell x_flag_gclk (
    .clk_in   (float_clk),
    .local_en (flag_clk_en),
    .clk_out  (flag_clk)
  );

  // ============================
  // Accrued flags and fe
  // ============================
  assign fflags_load = fcsr_wen | fflags_wen | fxcr_wen;

  // CSR write beats a same-cycle retire update
  always_ff @(posedge flag_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      fcsr_fflags <= '0;
    end
    else if (fflags_load) begin
      fcsr_fflags <= csr_wdata[4:0];
    end
    else if (retire_fflags_vld) begin
      fcsr_fflags <= fcsr_fflags | retire_fflags;
    end
  end

  // Sticky bit set by any raised retire flag
  always_ff @(posedge flag_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      fxcr_fe <= 1'b0;
    end
    else if (fxcr_wen) begin
      fxcr_fe <= csr_wdata[5];
    end
    else if (retire_fflags_vld) begin
      fxcr_fe <= fxcr_fe | (|retire_fflags);
    end
  end

  // ============================
  // Rounding mode and fxcr controls
  // ============================
  // Three views of the same frm field
  always_ff @(posedge float_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      fcsr_frm <= '0;
    end
    else if (fcsr_wen) begin
      fcsr_frm <= csr_wdata[7:5];
    end
    else if (frm_wen) begin
      fcsr_frm <= csr_wdata[2:0];
    end
    else if (fxcr_wen) begin
      fcsr_frm <= csr_wdata[26:24];
    end
  end

  always_ff @(posedge float_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      fxcr_dqnan <= 1'b0;
      fxcr_bf16  <= 1'b0;
    end
    else if (fxcr_wen) begin
      fxcr_dqnan <= csr_wdata[23];
      fxcr_bf16  <= csr_wdata[31];
    end
  end

  // Hardwired in this configuration
  // vtype reads as illegal
  assign vstart_vstart = '0;
  assign fcsr_vxsat    = 1'b0;
  assign fcsr_vxrm     = 2'b0;
  assign vl_vl         = '0;
  assign vtype_vill    = 1'b1;
  assign vtype_vsew    = 3'b0;
  assign vtype_vlmul   = 2'b0;

  // ============================
  // Read views and read port
  // ============================
  assign fflags_value = {59'b0, fcsr_fflags};
  assign frm_value    = {61'b0, fcsr_frm};
  assign fcsr_value   = {53'b0, fcsr_vxrm, fcsr_vxsat, fcsr_frm, fcsr_fflags};
  assign fxcr_value   = {32'b0, fxcr_bf16, 4'b0, fcsr_frm, fxcr_dqnan,
                         17'b0, fxcr_fe, fcsr_fflags};
  assign vstart_value = {57'b0, vstart_vstart};
  assign vxsat_value  = {63'b0, fcsr_vxsat};
  assign vxrm_value   = {62'b0, fcsr_vxrm};
  assign vl_value     = {56'b0, vl_vl};
  assign vtype_value  = {vtype_vill, 58'b0, vtype_vsew, vtype_vlmul};
  // VLEN in bytes
  assign vlenb_value  = float_csr_pkg::csr_data_t'(VLEN / 8);

  always_comb begin
    case (rd_sel)
      float_csr_pkg::SEL_FFLAGS: rd_value = fflags_value;
      float_csr_pkg::SEL_FRM:    rd_value = frm_value;
      float_csr_pkg::SEL_FCSR:   rd_value = fcsr_value;
      float_csr_pkg::SEL_VSTART: rd_value = vstart_value;
      float_csr_pkg::SEL_VXSAT:  rd_value = vxsat_value;
      float_csr_pkg::SEL_VXRM:   rd_value = vxrm_value;
      float_csr_pkg::SEL_VL:     rd_value = vl_value;
      float_csr_pkg::SEL_VTYPE:  rd_value = vtype_value;
      float_csr_pkg::SEL_VLENB:  rd_value = vlenb_value;
      float_csr_pkg::SEL_FXCR:   rd_value = fxcr_value;
      // Idle and unknown reads
      default:                   rd_value = '0;
    endcase
  end

  // One-cycle read latency
  always_ff @(posedge float_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      csr_rdata_vld <= 1'b0;
      csr_rdata     <= '0;
    end
    else begin
      csr_rdata_vld <= (rd_sel != float_csr_pkg::SEL_NONE);
      if (rd_sel != float_csr_pkg::SEL_NONE) begin
        csr_rdata <= rd_value;
      end
    end
  end

  // ============================
  // Execution and decode outputs
  // ============================
  assign frm   = fcsr_frm;
  assign dqnan = fxcr_dqnan;
  assign bf16  = fxcr_bf16;

  // vsetvl in flight overrides the stored vector state
  assign vl_bypass_zero = vsetvl_illegal | ~(|vsetvl_avl);

  assign idu_vill    = vsetvl_bypass ? vsetvl_vill    : vtype_vill;
  assign idu_vl_zero = vsetvl_bypass ? vl_bypass_zero : (vl_vl == '0);
  assign idu_vlmul   = vsetvl_bypass ? vsetvl_data[1:0] : vtype_vlmul;
  // Only the low two sew bits reach the decoder
  // Bit 4 of the bypass data is spare
  assign idu_vsew    = vsetvl_bypass ? vsetvl_data[3:2] : vtype_vsew[1:0];
  // Zero with or without a vsetvl in flight
  assign idu_vstart  = vstart_vstart;

  // Retire side start check
  assign vstart_eq_0 = (vstart_vstart == '0);

endmodule

// ==== src/float_csr_top.sv ====
`timescale 1ns/1ps

module float_csr_top #(
  parameter int VLEN = 128
) (
  input  logic                      float_clk,
  input  logic                      cpurst_b,
  // CSR access port
  input  logic                      csr_ren,
  input  logic                      csr_wen,
  input  float_csr_pkg::csr_addr_t  csr_addr,
  input  float_csr_pkg::csr_data_t  csr_wdata,
  output float_csr_pkg::csr_data_t  csr_rdata,
  output logic                      csr_rdata_vld,
  output logic                      csr_illegal,
  // Retire update
  input  logic                      retire_fflags_vld,
  input  float_csr_pkg::fflags_t    retire_fflags,
  // vsetvl bypass
  input  logic                      vsetvl_bypass,
  input  logic [4:0]                vsetvl_data,
  input  float_csr_pkg::csr_data_t  vsetvl_avl,
  input  logic                      vsetvl_illegal,
  input  logic                      vsetvl_vill,
  // Execution unit controls
  output float_csr_pkg::frm_t       frm,
  output logic                      dqnan,
  output logic                      bf16,
  // Decoder vector fields
  output logic                      idu_vill,
  output logic                      idu_vl_zero,
  output logic [1:0]                idu_vlmul,
  output logic [1:0]                idu_vsew,
  output float_csr_pkg::vstart_t    idu_vstart,
  output logic                      vstart_eq_0
);

  // Decode to register file
  logic                    fflags_wen;
  logic                    frm_wen;
  logic                    fcsr_wen;
  logic                    fxcr_wen;
  float_csr_pkg::csr_sel_t rd_sel;

  // ============================
  // Address decode
  // ============================
  float_csr_decode u_decode (
    .float_clk   (float_clk),
    .cpurst_b    (cpurst_b),
    .csr_ren     (csr_ren),
    .csr_wen     (csr_wen),
    .csr_addr    (csr_addr),
    .fflags_wen  (fflags_wen),
    .frm_wen     (frm_wen),
    .fcsr_wen    (fcsr_wen),
    .fxcr_wen    (fxcr_wen),
    .rd_sel      (rd_sel),
    .csr_illegal (csr_illegal)
  );

  // ============================
  // Register file
  // ============================
  float_csr_regs #(
    .VLEN (VLEN)
  ) u_regs (
    .float_clk         (float_clk),
    .cpurst_b          (cpurst_b),
    .fflags_wen        (fflags_wen),
    .frm_wen           (frm_wen),
    .fcsr_wen          (fcsr_wen),
    .fxcr_wen          (fxcr_wen),
    .rd_sel            (rd_sel),
    .csr_wdata         (csr_wdata),
    .retire_fflags_vld (retire_fflags_vld),
    .retire_fflags     (retire_fflags),
    .vsetvl_bypass     (vsetvl_bypass),
    .vsetvl_illegal    (vsetvl_illegal),
    .vsetvl_vill       (vsetvl_vill),
    .vsetvl_data       (vsetvl_data),
    .vsetvl_avl        (vsetvl_avl),
    .csr_rdata         (csr_rdata),
    .csr_rdata_vld     (csr_rdata_vld),
    .frm               (frm),
    .dqnan             (dqnan),
    .bf16              (bf16),
    .idu_vill          (idu_vill),
    .idu_vl_zero       (idu_vl_zero),
    .idu_vlmul         (idu_vlmul),
    .idu_vsew          (idu_vsew),
    .idu_vstart        (idu_vstart),
    .vstart_eq_0       (vstart_eq_0)
  );

endmodule

// ==== sim/float_csr_chk.sv ====
`timescale 1ns/1ps

module float_csr_chk (
  input logic                float_clk,
  input logic                cpurst_b,
  input logic                csr_ren,
  input logic                csr_wen,
  input logic                csr_rdata_vld,
  input logic                csr_illegal,
  input float_csr_pkg::frm_t frm
);

  // ============================
  // Access port protocol
  // ============================
  // Read data valid exactly one cycle after the read strobe
  a_rvld_follows_ren: assert property (@(posedge float_clk) disable iff (!cpurst_b)
    csr_ren |=> csr_rdata_vld)
    else $error("csr_rdata_vld missing one cycle after csr_ren");

  a_no_rvld_without_ren: assert property (@(posedge float_clk) disable iff (!cpurst_b)
    !csr_ren |=> !csr_rdata_vld)
    else $error("csr_rdata_vld raised without a preceding csr_ren");

  // Illegal pulse only as the answer to an access
  a_illegal_after_access: assert property (@(posedge float_clk) disable iff (!cpurst_b)
    csr_illegal |-> $past(csr_ren || csr_wen))
    else $error("csr_illegal raised without a preceding access");

  // frm moves only after a CSR write
  a_frm_after_write: assert property (@(posedge float_clk) disable iff (!cpurst_b)
    $changed(frm) |-> $past(csr_wen))
    else $error("frm changed without a preceding csr_wen");

  a_strobes_exclusive: assert property (@(posedge float_clk) disable iff (!cpurst_b)
    !(csr_ren && csr_wen))
    else $error("csr_ren and csr_wen high in the same cycle");

endmodule

bind float_csr_top float_csr_chk u_chk (
  .float_clk     (float_clk),
  .cpurst_b      (cpurst_b),
  .csr_ren       (csr_ren),
  .csr_wen       (csr_wen),
  .csr_rdata_vld (csr_rdata_vld),
  .csr_illegal   (csr_illegal),
  .frm           (frm)
);

// ==== sim/float_csr_clkgen.sv ====
`timescale 1ns/1ps

module float_csr_clkgen #(
  parameter int RST_CYCLES = 16
) (
  output logic float_clk,
  output logic cpurst_b
);

  // 10 ns period
  initial begin
    float_clk = 1'b0;
    forever #5 float_clk = ~float_clk;
  end

  // Release on a falling edge, away from the flops' sampling edge
  initial begin
    cpurst_b = 1'b0;
    repeat (RST_CYCLES) @(posedge float_clk);
    @(negedge float_clk);
    cpurst_b = 1'b1;
  end

endmodule

// ==== sim/float_csr_tb.sv ====
`timescale 1ns/1ps

module float_csr_tb;

  localparam int VLEN        = 128;
  // Test lengths in cycles
  localparam int N_WR_ITER   = 30;
  localparam int N_MIX       = 60;
  localparam int N_BYP       = 40;
  localparam int RUN_CYCLES  = 16 + 10 + N_WR_ITER * 5 + N_MIX + 4 + 17 + N_BYP;
  localparam int CYCLE_LIMIT = RUN_CYCLES + 50;

  logic                      float_clk;
  logic                      cpurst_b;
  logic                      csr_ren;
  logic                      csr_wen;
  float_csr_pkg::csr_addr_t  csr_addr;
  float_csr_pkg::csr_data_t  csr_wdata;
  float_csr_pkg::csr_data_t  csr_rdata;
  logic                      csr_rdata_vld;
  logic                      csr_illegal;
  logic                      retire_fflags_vld;
  float_csr_pkg::fflags_t    retire_fflags;
  logic                      vsetvl_bypass;
  logic [4:0]                vsetvl_data;
  float_csr_pkg::csr_data_t  vsetvl_avl;
  logic                      vsetvl_illegal;
  logic                      vsetvl_vill;
  float_csr_pkg::frm_t       frm;
  logic                      dqnan;
  logic                      bf16;
  logic                      idu_vill;
  logic                      idu_vl_zero;
  logic [1:0]                idu_vlmul;
  logic [1:0]                idu_vsew;
  float_csr_pkg::vstart_t    idu_vstart;
  logic                      vstart_eq_0;

  // Reference model state at its reset values
  logic [4:0] m_fflags = '0;
  logic [2:0] m_frm    = '0;
  logic       m_fe     = 1'b0;
  logic       m_dqnan  = 1'b0;
  logic       m_bf16   = 1'b0;
  int         seed      = 10;
  int         err_cnt   = 0;
  int         check_cnt = 0;
  int         cycle_cnt = 0;

  float_csr_clkgen #(.RST_CYCLES(16)) u_clkgen (
    .float_clk (float_clk),
    .cpurst_b  (cpurst_b)
  );

  float_csr_top #(.VLEN(VLEN)) dut (.*);

  // ============================
  // Timeout
  // ============================
  always @(posedge float_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  // ============================
  // Helpers
  // ============================
  function automatic logic [31:0] rand32();
    rand32 = $random(seed);
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    check_cnt++;
    if (actual !== expected) begin
      $display("ERR %s expected %h actual %h", name, expected, actual);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("Test %s: %s (%0d errors)", name,
             (err_cnt == errs_before) ? "ok" : "FAILED", err_cnt - errs_before);
  endtask

  // Writable ones first
  function automatic float_csr_pkg::csr_addr_t known_addr(input int idx);
    case (idx)
      0:       known_addr = float_csr_pkg::ADDR_FFLAGS;
      1:       known_addr = float_csr_pkg::ADDR_FRM;
      2:       known_addr = float_csr_pkg::ADDR_FCSR;
      3:       known_addr = float_csr_pkg::ADDR_FXCR;
      4:       known_addr = float_csr_pkg::ADDR_VSTART;
      5:       known_addr = float_csr_pkg::ADDR_VXSAT;
      6:       known_addr = float_csr_pkg::ADDR_VXRM;
      7:       known_addr = float_csr_pkg::ADDR_VL;
      8:       known_addr = float_csr_pkg::ADDR_VTYPE;
      default: known_addr = float_csr_pkg::ADDR_VLENB;
    endcase
  endfunction

  function automatic logic is_known(input float_csr_pkg::csr_addr_t addr);
    for (int i = 0; i < 10; i++) begin
      if (addr == known_addr(i)) return 1'b1;
    end
    return 1'b0;
  endfunction

  // Read layouts from the model
  function automatic logic [63:0] expected_read(input float_csr_pkg::csr_addr_t addr);
    logic [63:0] v;
    v = '0;
    if (addr == float_csr_pkg::ADDR_FFLAGS) begin
      v[4:0] = m_fflags;
    end else if (addr == float_csr_pkg::ADDR_FRM) begin
      v[2:0] = m_frm;
    end else if (addr == float_csr_pkg::ADDR_FCSR) begin
      v[7:5] = m_frm;
      v[4:0] = m_fflags;
    end else if (addr == float_csr_pkg::ADDR_FXCR) begin
      v[31]    = m_bf16;
      v[26:24] = m_frm;
      v[23]    = m_dqnan;
      v[5]     = m_fe;
      v[4:0]   = m_fflags;
    end else if (addr == float_csr_pkg::ADDR_VTYPE) begin
      v[63] = 1'b1;
    end else if (addr == float_csr_pkg::ADDR_VLENB) begin
      v = 64'(VLEN / 8);
    end
    return v;
  endfunction

  function automatic logic illegal_expected(input logic rd, input logic wr,
                                            input float_csr_pkg::csr_addr_t addr);
    logic ro;
    ro = (addr == float_csr_pkg::ADDR_VL) || (addr == float_csr_pkg::ADDR_VTYPE) ||
         (addr == float_csr_pkg::ADDR_VLENB);
    return ((rd || wr) && !is_known(addr)) || (wr && ro);
  endfunction

  // Write beats retire across the three frm views
  task automatic update_model(input logic wr, input float_csr_pkg::csr_addr_t addr,
                              input logic [63:0] wdata, input logic rt_vld,
                              input logic [4:0] rt);
    logic wr_fflags;
    logic wr_frm;
    logic wr_fcsr;
    logic wr_fxcr;
    wr_fflags = wr && (addr == float_csr_pkg::ADDR_FFLAGS);
    wr_frm    = wr && (addr == float_csr_pkg::ADDR_FRM);
    wr_fcsr   = wr && (addr == float_csr_pkg::ADDR_FCSR);
    wr_fxcr   = wr && (addr == float_csr_pkg::ADDR_FXCR);
    if (wr_fflags || wr_fcsr || wr_fxcr) m_fflags = wdata[4:0];
    else if (rt_vld) m_fflags = m_fflags | rt;
    if (wr_fxcr) m_fe = wdata[5];
    else if (rt_vld && (rt != 5'd0)) m_fe = 1'b1;
    if (wr_fcsr) m_frm = wdata[7:5];
    else if (wr_frm) m_frm = wdata[2:0];
    else if (wr_fxcr) m_frm = wdata[26:24];
    if (wr_fxcr) begin
      m_dqnan = wdata[23];
      m_bf16  = wdata[31];
    end
  endtask

  // One access cycle entered and left on a falling edge
  task automatic csr_access(input logic rd, input logic wr,
                            input float_csr_pkg::csr_addr_t addr, input logic [63:0] wdata,
                            input logic rt_vld, input logic [4:0] rt);
    logic [63:0] exp_rdata;
    logic        exp_illegal;
    exp_rdata         = expected_read(addr);
    exp_illegal       = illegal_expected(rd, wr, addr);
    csr_ren           = rd;
    csr_wen           = wr;
    csr_addr          = addr;
    csr_wdata         = wdata;
    retire_fflags_vld = rt_vld;
    retire_fflags     = rt;
    @(negedge float_clk);
    csr_ren           = 1'b0;
    csr_wen           = 1'b0;
    retire_fflags_vld = 1'b0;
    update_model(wr, addr, wdata, rt_vld, rt);
    check_value("csr_rdata_vld", 64'(rd), 64'(csr_rdata_vld));
    if (rd) check_value("csr_rdata", exp_rdata, csr_rdata);
    check_value("csr_illegal", 64'(exp_illegal), 64'(csr_illegal));
    check_value("frm", 64'(m_frm), 64'(frm));
    check_value("dqnan", 64'(m_dqnan), 64'(dqnan));
    check_value("bf16", 64'(m_bf16), 64'(bf16));
  endtask

  // ============================
  // Tests
  // ============================
  task automatic reset_reads();
    int errs_before;
    errs_before = err_cnt;
    for (int i = 0; i < 10; i++) csr_access(1'b1, 1'b0, known_addr(i), '0, 1'b0, '0);
    report_test("reset_reads", errs_before);
  endtask

  task automatic random_writes();
    int          errs_before;
    logic [31:0] r;
    errs_before = err_cnt;
    for (int n = 0; n < N_WR_ITER; n++) begin
      r = rand32();
      csr_access(1'b0, 1'b1, known_addr(int'(r[1:0])), {rand32(), rand32()}, 1'b0, '0);
      // Every view of the shared fields
      for (int i = 0; i < 4; i++) csr_access(1'b1, 1'b0, known_addr(i), '0, 1'b0, '0);
    end
    report_test("writes", errs_before);
  endtask

  task automatic retire_mix();
    int          errs_before;
    logic [31:0] r;
    errs_before = err_cnt;
    for (int n = 0; n < N_MIX; n++) begin
      r = rand32();
      // Retire in three cycles of four
      // Access kind in bits 9:8
      case (r[9:8])
        2'd2:    csr_access(1'b0, 1'b1, known_addr(int'(r[11:10])), {rand32(), rand32()},
                            r[0] | r[1], r[6:2]);
        2'd3:    csr_access(1'b1, 1'b0, known_addr(int'(r[11:10])), '0, r[0] | r[1], r[6:2]);
        default: csr_access(1'b0, 1'b0, known_addr(0), '0, r[0] | r[1], r[6:2]);
      endcase
    end
    for (int i = 0; i < 4; i++) csr_access(1'b1, 1'b0, known_addr(i), '0, 1'b0, '0);
    report_test("retire_mix", errs_before);
  endtask

  task automatic illegal_accesses();
    int                       errs_before;
    logic [31:0]              r;
    float_csr_pkg::csr_addr_t addr;
    errs_before = err_cnt;
    // Unknown addresses on reads and writes
    for (int n = 0; n < 8; n++) begin
      r    = rand32();
      addr = r[11:0];
      while (is_known(addr)) addr = addr + 12'd1;
      csr_access(!r[12], r[12], addr, {rand32(), rand32()}, 1'b0, '0);
    end
    // Read-only vector CSRs fault on write
    for (int i = 7; i < 10; i++) csr_access(1'b0, 1'b1, known_addr(i), '1, 1'b0, '0);
    // WARL zero writes dropped silently
    for (int i = 4; i < 7; i++) csr_access(1'b0, 1'b1, known_addr(i), '1, 1'b0, '0);
    for (int i = 4; i < 7; i++) csr_access(1'b1, 1'b0, known_addr(i), '0, 1'b0, '0);
    report_test("illegal", errs_before);
  endtask

  task automatic bypass_outputs();
    int          errs_before;
    logic [31:0] r;
    logic [63:0] avl;
    logic        byp;
    errs_before = err_cnt;
    for (int n = 0; n < N_BYP; n++) begin
      r   = rand32();
      avl = {rand32(), rand32()};
      // Zero AVL in about one case of four
      if (r[1:0] == 2'b00) avl = '0;
      byp            = r[2];
      vsetvl_bypass  = byp;
      vsetvl_illegal = r[3] & r[4];
      vsetvl_vill    = r[5];
      vsetvl_data    = r[10:6];
      vsetvl_avl     = avl;
      @(negedge float_clk);
      check_value("idu_vill", 64'(byp ? r[5] : 1'b1), 64'(idu_vill));
      check_value("idu_vl_zero", 64'(byp ? ((r[3] & r[4]) | (avl == '0)) : 1'b1),
                  64'(idu_vl_zero));
      check_value("idu_vlmul", 64'(byp ? r[7:6] : 2'b00), 64'(idu_vlmul));
      check_value("idu_vsew", 64'(byp ? r[9:8] : 2'b00), 64'(idu_vsew));
      check_value("idu_vstart", 64'(0), 64'(idu_vstart));
      check_value("vstart_eq_0", 64'(1), 64'(vstart_eq_0));
    end
    vsetvl_bypass = 1'b0;
    report_test("bypass", errs_before);
  endtask

  // ============================
  // Main sequence
  // ============================
  initial begin
    csr_ren           = 1'b0;
    csr_wen           = 1'b0;
    csr_addr          = '0;
    csr_wdata         = '0;
    retire_fflags_vld = 1'b0;
    retire_fflags     = '0;
    vsetvl_bypass     = 1'b0;
    vsetvl_data       = '0;
    vsetvl_avl        = '0;
    vsetvl_illegal    = 1'b0;
    vsetvl_vill       = 1'b0;
    wait (cpurst_b === 1'b1);
    @(negedge float_clk);
    reset_reads();
    random_writes();
    retire_mix();
    illegal_accesses();
    bypass_outputs();
    $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== list.f ====
common/float_csr_pkg.sv
src/gated_clk_cell.sv
float_csr/float_csr_decode.sv
float_csr/float_csr_regs.sv
src/float_csr_top.sv
sim/float_csr_chk.sv
sim/float_csr_clkgen.sv
sim/float_csr_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --timing --assert
TOP       := float_csr_tb
FILELIST  := list.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Simulation failed
PASS_MSG  := Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Failure reported in $(LOG)"; \
	  exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Run ended without a result, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
